// File: Bender.yml
package:
  name: nes_dma

sources:
  - files:
      - logic/nes_dma_pkg.sv
      - logic/cpu_phase_divider.sv
      - logic/dmc_dma_unit.sv
      - logic/oam_dma_engine.sv
      - logic/nes_dma_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/nes_dma_tb.sv

// File: compile.f
logic/nes_dma_pkg.sv
logic/cpu_phase_divider.sv
logic/dmc_dma_unit.sv
logic/oam_dma_engine.sv
logic/nes_dma_top.sv
verif/tb_clock.sv
verif/nes_dma_tb.sv

// File: logic/cpu_phase_divider.sv
//======================================================================
// CPU clock divider, makes the CPU enable and the get/put phase
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module cpu_phase_divider
	import nes_dma_pkg::*;
#(
	parameter int CPU_DIV = DEFAULT_CPU_DIV
) (
	input  logic   clk,
	input  logic   reset,
	output phase_t phase
);

	localparam int CNT_W = $clog2(CPU_DIV + 1);

	logic [CNT_W-1:0] div_count;    // Runs 1 .. CPU_DIV
	logic             cpu_ce;
	logic             put_cycle;    // 1 == odd (put), 0 == even (get)

	assign cpu_ce = (div_count == CNT_W'(CPU_DIV));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_count <= CNT_W'(1);
			put_cycle <= 1'b1;      // First cycle out of reset is a put
		end else begin
			div_count <= cpu_ce ? CNT_W'(1) : div_count + CNT_W'(1);
			if (cpu_ce)
				put_cycle <= ~put_cycle;    // Strict get/put alternation
		end
	end

	// Phase is split here only, the DMA blocks just use the strobes
	assign phase.cpu_ce    = cpu_ce;
	assign phase.put_cycle = put_cycle;
	assign phase.get_ce    = cpu_ce & put_cycle;    // Put ends, get begins
	assign phase.put_ce    = cpu_ce & ~put_cycle;   // Get ends, put begins

	// One tick type at a time
	assert property (@(posedge clk) disable iff (reset)
		!(phase.get_ce && phase.put_ce))
	else
		$error("get_ce and put_ce high together");

	// CPU tick spacing is exactly CPU_DIV master clocks
	assert property (@(posedge clk) disable iff (reset)
		phase.cpu_ce |=> !phase.cpu_ce [* CPU_DIV - 1] ##1 phase.cpu_ce)
	else
		$error("cpu_ce period differs from CPU_DIV");

endmodule

`default_nettype wire

// File: logic/dmc_dma_unit.sv
//======================================================================
// DMC DMA, steals one get cycle per sample fetch and pauses the CPU
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module dmc_dma_unit
	import nes_dma_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  phase_t   phase,
	input  logic     cpu_rnw,
	input  dmc_req_t dmc_req,
	output logic     dmc_ack,
	output logic     dmc_busy,
	output logic     dmc_pause
);

	// Set for one put cycle and the get cycle after it
	logic dmc_state;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
		end else if (phase.put_ce) begin
			if (dmc_state)
				dmc_state <= 1'b0;              // Stolen get cycle is over
			else if (dmc_req.trigger && cpu_rnw)
				dmc_state <= 1'b1;              // Only once the CPU sits in a read
		end
	end

	// The channel can drop its request before the slot ends,
	// so the ack follows the trigger too
	assign dmc_ack = dmc_state & ~phase.put_cycle & dmc_req.trigger;

	assign dmc_busy  = dmc_state;
	assign dmc_pause = dmc_req.trigger | dmc_state;    // Halt from request to end of fetch

	// Ack only inside a get cycle of the divider
	assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> !phase.put_cycle)
	else
		$error("dmc_ack outside a get cycle");

endmodule

`default_nettype wire

// File: logic/nes_dma_pkg.sv
//======================================================================
// NES DMA shared types, bus register addresses and packed structs
//======================================================================
`default_nettype none

package nes_dma_pkg;

	typedef logic [15:0] addr_t;    // CPU bus address
	typedef logic [7:0]  byte_t;    // Bus data byte

	localparam addr_t OAM_DMA_REG  = 16'h4014;  // Sprite DMA page register
	localparam addr_t OAM_DATA_REG = 16'h2004;  // PPU OAM data port, target of DMA writes

	localparam int DEFAULT_CPU_DIV = 12;        // Master clocks per CPU cycle

	// CPU cycle strobes
	// get_ce and put_ce fire on the cpu_ce that opens a cycle of that kind
	typedef struct packed {
		logic cpu_ce;       // One clock per CPU cycle
		logic put_cycle;    // High during odd (put) cycles
		logic get_ce;       // Tick into a get cycle
		logic put_ce;       // Tick into a put cycle
	} phase_t;

	// Bus request from the CPU core
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  rnw;             // 1 while reading
		logic  write_strobe;    // Single clock on a CPU write
	} cpu_bus_t;

	// DMA side of the bus
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  enable;      // DMA owns the bus
		logic  read;        // 1 = read, 0 = write
	} dma_bus_t;

	// Sample fetch request from the DMC channel
	typedef struct packed {
		logic  trigger;     // Held until acknowledged
		addr_t addr;
	} dmc_req_t;

endpackage

`default_nettype wire

// File: logic/nes_dma_top.sv
//======================================================================
// NES DMA top, CPU phase divider plus DMC and sprite DMA controllers
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module nes_dma_top
	import nes_dma_pkg::*;
#(
	parameter int CPU_DIV = DEFAULT_CPU_DIV
) (
	input  logic     clk,
	input  logic     reset,
	input  cpu_bus_t cpu_bus,
	input  dmc_req_t dmc_req,
	input  byte_t    bus_rdata,
	output dma_bus_t dma_bus,
	output logic     dmc_ack,
	output logic     pause_cpu
);

	phase_t phase;          // CPU tick and get/put strobes
	logic   dmc_busy;       // DMC fetch in progress
	logic   dmc_pause;

	cpu_phase_divider #(
		.CPU_DIV (CPU_DIV)
	) u_divider (
		.clk   (clk),
		.reset (reset),
		.phase (phase)
	);

	dmc_dma_unit u_dmc (
		.clk       (clk),
		.reset     (reset),
		.phase     (phase),
		.cpu_rnw   (cpu_bus.rnw),
		.dmc_req   (dmc_req),
		.dmc_ack   (dmc_ack),
		.dmc_busy  (dmc_busy),
		.dmc_pause (dmc_pause)
	);

	oam_dma_engine u_oam (
		.clk       (clk),
		.reset     (reset),
		.phase     (phase),
		.cpu_bus   (cpu_bus),
		.dmc_req   (dmc_req),
		.dmc_ack   (dmc_ack),
		.dmc_busy  (dmc_busy),
		.dmc_pause (dmc_pause),
		.bus_rdata (bus_rdata),
		.dma_bus   (dma_bus),
		.pause_cpu (pause_cpu)
	);

endmodule

`default_nettype wire

// File: logic/oam_dma_engine.sv
//======================================================================
// Sprite DMA, copies one 256 byte page to OAM and muxes the DMA bus
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module oam_dma_engine
	import nes_dma_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  phase_t   phase,
	input  cpu_bus_t cpu_bus,
	input  dmc_req_t dmc_req,
	input  logic     dmc_ack,
	input  logic     dmc_busy,
	input  logic     dmc_pause,
	input  byte_t    bus_rdata,
	output dma_bus_t dma_bus,
	output logic     pause_cpu
);

	// Bit 0 means the CPU is held, bit 1 means the transfer runs
	localparam logic [1:0] OAM_IDLE    = 2'b00;
	localparam logic [1:0] OAM_PENDING = 2'b01;
	localparam logic [1:0] OAM_ACTIVE  = 2'b11;

	logic [1:0] oam_state;
	addr_t      page_addr;      // Page in the high byte, byte index in the low byte
	byte_t      byte_latch;     // Fetched byte, held for its put cycle
	logic [8:0] addr_next;      // Bit 8 is the carry out of the index
	logic       oam_start;
	logic       oam_owns;       // Sprite DMA drives the bus

	assign oam_start = cpu_bus.write_strobe && (cpu_bus.addr == OAM_DMA_REG) && phase.cpu_ce;
	assign addr_next = {1'b0, page_addr[7:0]} + 9'd1;

	// A get cycle taken by the DMC is not ours
	assign oam_owns = oam_state[1] && !(dmc_busy && !phase.put_cycle);

	always_ff @(posedge clk) begin
		if (reset) begin
			oam_state <= OAM_IDLE;
		end else if (oam_state[1] && phase.get_ce && addr_next[8]) begin
			oam_state <= OAM_IDLE;      // Byte FF is written, page done
		end else if (oam_state[1] && phase.put_ce && dmc_busy) begin
			oam_state <= OAM_PENDING;   // Sit out the put, nothing new was fetched
		end else if (oam_state == OAM_PENDING && phase.get_ce && cpu_bus.rnw) begin
			oam_state <= OAM_ACTIVE;    // Next cycle is a get, start reading
		end else if (oam_start) begin
			oam_state <= OAM_PENDING;
		end
	end

	always_ff @(posedge clk) begin
		if (oam_start)
			page_addr <= {cpu_bus.wdata, 8'h00};
		else if (oam_state[1] && phase.get_ce)
			page_addr[7:0] <= addr_next[7:0];   // Advance once the put is done

		// Follow read data through our get cycle, the last clock wins
		if (oam_owns && !phase.put_cycle)
			byte_latch <= bus_rdata;
	end

	// DMC fetch first, then page read on get, OAM port on put
	always_comb begin
		if (dmc_ack)
			dma_bus.addr = dmc_req.addr;
		else if (!phase.put_cycle)
			dma_bus.addr = page_addr;
		else
			dma_bus.addr = OAM_DATA_REG;
	end

	assign dma_bus.wdata  = byte_latch;
	assign dma_bus.enable = dmc_ack | oam_owns;
	assign dma_bus.read   = ~phase.put_cycle;          // Get reads, put writes

	assign pause_cpu = oam_state[0] | dmc_pause;

	// 2'b10 has no meaning
	assert property (@(posedge clk) disable iff (reset)
		oam_state != 2'b10)
	else
		$error("OAM DMA state in unused encoding");

	// A DMC ack owns the bus alone, the sprite copy stands aside
	assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> dma_bus.enable && !oam_owns)
	else
		$error("DMC ack without sole DMA bus ownership");

endmodule

`default_nettype wire

// File: verif/nes_dma_tb.sv
//======================================================================
// Testbench for the NES DMA block, sprite page copies with DMC fetches
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module nes_dma_tb
	import nes_dma_pkg::*;
();

	localparam int CPU_DIV     = DEFAULT_CPU_DIV;
	localparam int CLK_NS      = 8;
	localparam int XFER_CYCLES = 600;     // CPU cycles budgeted per page copy
	localparam int TIMEOUT_NS  = 4 * XFER_CYCLES * CPU_DIV * CLK_NS + 20000;

	logic     clk;
	logic     reset;
	cpu_bus_t cpu_bus;
	dmc_req_t dmc_req;
	byte_t    bus_rdata;
	dma_bus_t dma_bus;
	logic     dmc_ack;
	logic     pause_cpu;

	byte_t  mem [0:65535];      // Whole CPU address space
	integer seed;

	int   tb_div = 1;           // Mirror of the CPU tick counter
	logic tb_put = 1'b1;        // Mirror of the get/put phase
	logic tb_cpu_ce;

	logic  quiet;               // No request issued yet
	addr_t exp_addr;            // Next page address the copy must read
	addr_t last_read_addr;
	byte_t exp_wdata;           // Memory byte behind the latest OAM read
	int    read_count   = 0;
	int    write_count  = 0;
	int    ack_count    = 0;
	int    dmc_requests = 0;
	logic  prev_oam_read;
	logic  prev_oam_write;
	logic  oam_read;
	logic  oam_write;
	logic  oam_start;

	tb_clock #(
		.PERIOD_NS    (CLK_NS),
		.RESET_CYCLES (3)
	) u_clock (
		.clk   (clk),
		.reset (reset)
	);

	nes_dma_top #(
		.CPU_DIV (CPU_DIV)
	) UUT (
		.clk       (clk),
		.reset     (reset),
		.cpu_bus   (cpu_bus),
		.dmc_req   (dmc_req),
		.bus_rdata (bus_rdata),
		.dma_bus   (dma_bus),
		.dmc_ack   (dmc_ack),
		.pause_cpu (pause_cpu)
	);

	assign bus_rdata = mem[dma_bus.addr];   // Memory answers in the same clock
	assign tb_cpu_ce = (tb_div == CPU_DIV);
	assign oam_read  = dma_bus.enable && dma_bus.read && !dmc_ack;
	assign oam_write = dma_bus.enable && !dma_bus.read;
	assign oam_start = cpu_bus.write_strobe && (cpu_bus.addr == OAM_DMA_REG) && tb_cpu_ce;

	// One CPU tick every CPU_DIV clocks, first cycle after reset is a put
	always @(posedge clk) begin
		if (reset) begin
			tb_div <= 1;
			tb_put <= 1'b1;
		end else begin
			tb_div <= tb_cpu_ce ? 1 : tb_div + 1;
			if (tb_cpu_ce)
				tb_put <= ~tb_put;
		end
	end

	always @(posedge clk) begin
		prev_oam_read  <= oam_read;
		prev_oam_write <= oam_write;
		if (oam_start) begin
			exp_addr    <= {cpu_bus.wdata, 8'h00};  // Page from the written data
			read_count  <= 0;
			write_count <= 0;
		end
		if (oam_read) begin
			last_read_addr <= dma_bus.addr;
			exp_wdata      <= mem[dma_bus.addr];
		end
		if (oam_read && !prev_oam_read) begin
			exp_addr[7:0] <= exp_addr[7:0] + 8'd1;
			read_count    <= read_count + 1;
		end
		if (oam_write && !prev_oam_write)
			write_count <= write_count + 1;
		if (dmc_ack)
			ack_count <= ack_count + 1;         // Counts ack clocks, one per request
	end

	task automatic flag_mismatch(input string test_name, input int unsigned expected,
			input int unsigned actual);
		$display("Test failed");
		$fatal(1, "[FAIL] %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
	endtask

	task automatic halt_on_error(input string what);
		$display("Test failed");
		$fatal(1, "%s", what);
	endtask

	quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		quiet |-> !dma_bus.enable && !pause_cpu && !dmc_ack)
	else
		halt_on_error("DMA bus, CPU pause or DMC ack active before any request");

	start_pauses: assert property (@(posedge clk) disable iff (reset)
		oam_start |=> pause_cpu)
	else
		halt_on_error("pause_cpu did not rise after the OAM DMA register write");

	// A new read takes the next page address and holds it through the get cycle
	read_addr: assert property (@(posedge clk) disable iff (reset)
		oam_read |-> dma_bus.addr == (prev_oam_read ? last_read_addr : exp_addr))
	else
		flag_mismatch("oam_read_addr", $sampled(prev_oam_read ? last_read_addr : exp_addr),
			$sampled(dma_bus.addr));

	write_addr: assert property (@(posedge clk) disable iff (reset)
		oam_write |-> dma_bus.addr == OAM_DATA_REG)
	else
		flag_mismatch("oam_write_addr", OAM_DATA_REG, $sampled(dma_bus.addr));

	write_data: assert property (@(posedge clk) disable iff (reset)
		oam_write |-> dma_bus.wdata == exp_wdata)
	else
		flag_mismatch("oam_write_data", $sampled(exp_wdata), $sampled(dma_bus.wdata));

	write_order: assert property (@(posedge clk) disable iff (reset)
		oam_write && !prev_oam_write |-> write_count < read_count)
	else
		halt_on_error("OAM write without a fresh read before it");

	bus_phase: assert property (@(posedge clk) disable iff (reset)
		dma_bus.enable |-> dma_bus.read == !tb_put)   // Get reads, put writes
	else
		halt_on_error("DMA read or write in the wrong half of the get/put pair");

	// Last write done and no DMC waiting, so the bus must be released
	end_release: assert property (@(posedge clk) disable iff (reset)
		prev_oam_write && !oam_write && write_count == 256 && !dmc_req.trigger
		|-> !dma_bus.enable && !pause_cpu)
	else
		halt_on_error("DMA bus or CPU pause still held after the last OAM write");

	dmc_addr: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> dma_bus.addr == dmc_req.addr)
	else
		flag_mismatch("dmc_fetch_addr", $sampled(dmc_req.addr), $sampled(dma_bus.addr));

	dmc_slot: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> dma_bus.enable && dma_bus.read && !tb_put && ack_count < dmc_requests)
	else
		halt_on_error("DMC ack outside a single get cycle of its own request");

	pause_hold: assert property (@(posedge clk) disable iff (reset)
		dmc_req.trigger || oam_read || oam_write |-> pause_cpu)
	else
		halt_on_error("CPU not paused while a DMA is pending or active");

	// Returns 1 ns into a clock that ends on a CPU tick
	task automatic align_to_cpu_tick();
		@(posedge clk);
		#1;
		while (!tb_cpu_ce) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic cpu_write(input addr_t addr, input byte_t data);
		align_to_cpu_tick();
		cpu_bus.addr         = addr;
		cpu_bus.wdata        = data;
		cpu_bus.rnw          = 1'b0;
		cpu_bus.write_strobe = 1'b1;
		@(posedge clk);
		#1;
		cpu_bus.write_strobe = 1'b0;
		cpu_bus.rnw          = 1'b1;
	endtask

	// Trigger stays up until the ack has been on the bus for one edge
	task automatic request_dmc(input addr_t addr);
		dmc_req.addr    = addr;
		dmc_req.trigger = 1'b1;
		dmc_requests++;
		@(posedge clk);
		#1;
		while (!dmc_ack) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		dmc_req.trigger = 1'b0;
	endtask

	task automatic wait_unpaused();
		while (pause_cpu) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Negative dmc_after means a copy with no DMC fetch
	task automatic copy_page(input byte_t page, input int dmc_after, input addr_t dmc_addr);
		cpu_write(OAM_DMA_REG, page);
		if (dmc_after >= 0) begin
			while (write_count < dmc_after) begin
				@(posedge clk);
				#1;
			end
			request_dmc(dmc_addr);
		end
		wait_unpaused();
		read_total: assert (read_count == 256)
		else
			flag_mismatch("oam_read_count", 256, read_count);
		write_total: assert (write_count == 256)
		else
			flag_mismatch("oam_write_count", 256, write_count);
	endtask

	initial begin
		cpu_bus.addr         = '0;
		cpu_bus.wdata        = '0;
		cpu_bus.rnw          = 1'b1;
		cpu_bus.write_strobe = 1'b0;
		dmc_req              = '0;
		quiet                = 1'b1;
		seed                 = 32'h1776_6b13;
		for (int i = 0; i < 65536; i++)
			mem[i] = byte_t'($random(seed));
		@(negedge reset);
		repeat (4 * CPU_DIV) @(posedge clk);    // Idle bus first
		#1;
		quiet = 1'b0;
		copy_page(8'h03, -1, '0);
		request_dmc(16'hC123);                  // DMC fetch on an idle bus
		wait_unpaused();
		copy_page(8'h87, 100, 16'hD456);        // Steal in mid transfer
		copy_page(8'h5A, 0, 16'hE789);          // Steal while the copy is pending
		copy_page(8'hFF, 255, 16'hC000);        // Steal over the final byte
		ack_total: assert (ack_count == dmc_requests)
		else
			flag_mismatch("dmc_ack_count", dmc_requests, ack_count);
		$display("Test passed");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Test failed");
		$fatal(1, "Watchdog expired after %0d ns with tests still running", TIMEOUT_NS);
	end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
//======================================================================
// Testbench clock source and power-on reset
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	// Reset drops just after an edge like the rest of the stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire
